// File: bench/ccipCheckerTb.sv
/*
 * Testbench for the request port checker, drives inputs on the falling edge
 * Expected status, count and first-violation values come from a local model
 * Write burst expectations are given per scenario from the write rules
 * Stops at the first failed check, a watchdog bounds the run
 */
`timescale 1ns/1ps

module ccipCheckerTb;

   localparam int ClkPeriod = 100;
   localparam int TestCycles = 750;
   localparam int MarginCycles = 200;

   logic clk, reset;
   logic c0Valid, c0Full, c1Valid, c1Sop, c1Full;
   logic [3:0] c0ReqType, c1ReqType;
   logic [1:0] c0Len, c1Len, c1Vc;
   logic [41:0] c0Addr, c1Addr, base;
   logic [3:0] paddr;
   logic psel, penable, pwrite, pready, pslverr, irq;
   logic [31:0] pwdata, prdata, rdData;
   logic rdErr;

   // Reference model of the register contents
   logic [15:0] lfsr;
   logic [9:0] expStatus, expMask;
   int expCount;
   logic expFirstValid;
   logic [3:0] expFirstIdx;

   ccipChecker u_ccipChecker (
      .clk(clk), .reset(reset),
      .c0Valid(c0Valid), .c0ReqType(c0ReqType), .c0Len(c0Len), .c0Addr(c0Addr),
      .c0Full(c0Full),
      .c1Valid(c1Valid), .c1ReqType(c1ReqType), .c1Len(c1Len), .c1Addr(c1Addr),
      .c1Vc(c1Vc), .c1Sop(c1Sop), .c1Full(c1Full),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr), .irq(irq)
   );

   initial begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   // Zero wait states on every cycle
   readyHigh: assert property (@(posedge clk) disable iff (reset) pready)
      else begin
         $display("pready dropped low at time %0t", $time);
         $display("TEST FAILED");
         $fatal(1, "pready low");
      end

   initial begin
      #(ClkPeriod * (TestCycles + MarginCycles));
      $display("Timeout: the tests did not finish in the expected time");
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      sameValue: assert (actual === expected) else begin
         $display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
                  $time, name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   // Galois LFSR, one step per bit taken
   function automatic logic [41:0] takeBits(input int n);
      logic [41:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         value = {value[40:0], lfsr[0]};
      end
      return value;
   endfunction

   task automatic alignedAddr(input logic [1:0] len, output logic [41:0] addr);
      addr = takeBits(42);
      if (len == ccipCheckPkg::Len2Cl) addr[0] = 1'b0;
      if (len == ccipCheckPkg::Len4Cl) addr[1:0] = 2'b00;
   endtask

   function automatic logic [9:0] violBit(input int idx);
      return 10'(1) << idx;
   endfunction

   // Read rules, written out from the rule list
   function automatic logic [9:0] readRules(input logic [3:0] t, input logic [1:0] len,
                                            input logic [41:0] addr, input logic full);
      logic [9:0] bits;
      bits = '0;
      if (t != ccipCheckPkg::ReqRdLineS && t != ccipCheckPkg::ReqRdLineI)
         bits |= violBit(ccipCheckPkg::RdBadType);
      if (len == ccipCheckPkg::Len3Cl) bits |= violBit(ccipCheckPkg::RdIllegalLen);
      if ((len == ccipCheckPkg::Len2Cl && addr[0]) ||
          (len == ccipCheckPkg::Len4Cl && addr[1:0] != 2'b00))
         bits |= violBit(ccipCheckPkg::RdMisaligned);
      if (full) bits |= violBit(ccipCheckPkg::RdOverflow);
      return bits;
   endfunction

   task automatic noteViol(input logic [9:0] bits);
      expStatus |= bits;
      for (int i = 0; i < 10; i++) begin
         if (bits[i] && expCount < 255) expCount++;
      end
      // Lowest index of the first violating cycle
      if (!expFirstValid && bits != '0) begin
         expFirstValid = 1'b1;
         for (int i = 9; i >= 0; i--) begin
            if (bits[i]) expFirstIdx = 4'(i);
         end
      end
   endtask

   task automatic sendRead(input logic [3:0] t, input logic [1:0] len,
                           input logic [41:0] addr, input logic full);
      @(negedge clk);
      c0Valid = 1'b1;
      c0ReqType = t;
      c0Len = len;
      c0Addr = addr;
      c0Full = full;
      @(negedge clk);
      c0Valid = 1'b0;
      c0Full = 1'b0;
      noteViol(readRules(t, len, addr, full));
   endtask

   task automatic sendWrite(input logic [3:0] t, input logic [1:0] len, input logic [41:0] addr,
                            input logic [1:0] vc, input logic sop, input logic full);
      @(negedge clk);
      c1Valid = 1'b1;
      c1ReqType = t;
      c1Len = len;
      c1Addr = addr;
      c1Vc = vc;
      c1Sop = sop;
      c1Full = full;
      @(negedge clk);
      c1Valid = 1'b0;
      c1Full = 1'b0;
   endtask

   // Legal burst, beat index added to the base, idle cycle between beats
   task automatic writeBurst(input logic [1:0] len, input logic [41:0] addr,
                             input logic [1:0] vc, input int firstBeat);
      for (int i = firstBeat; i <= int'(len); i++) begin
         sendWrite(ccipCheckPkg::ReqWrLineM, len, addr + 42'(i), vc, i == 0, 1'b0);
      end
   endtask

   task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data);
      @(negedge clk);
      psel = 1'b1;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic apbRead(input logic [3:0] addr, output logic [31:0] data,
                          output logic err);
      @(negedge clk);
      psel = 1'b1;
      paddr = addr;
      @(negedge clk);
      penable = 1'b1;
      #1;
      data = prdata;
      err = pslverr;
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic clearStatus(input logic [9:0] bits);
      apbWrite(ccipCheckPkg::RegStatus, {22'd0, bits});
      expStatus &= ~bits;
   endtask

   task automatic checkRegs();
      apbRead(ccipCheckPkg::RegStatus, rdData, rdErr);
      checkValue("RegStatus", {22'd0, expStatus}, rdData);
      checkValue("pslverr", 32'd0, {31'd0, rdErr});
      apbRead(ccipCheckPkg::RegCount, rdData, rdErr);
      checkValue("RegCount", 32'(expCount), rdData);
      apbRead(ccipCheckPkg::RegFirst, rdData, rdErr);
      checkValue("RegFirst", {expFirstValid, 27'd0, expFirstIdx}, rdData);
      checkValue("irq", {31'd0, |(expStatus & expMask)}, {31'd0, irq});
   endtask

   initial begin
      lfsr = 16'd98;
      {c0Valid, c0Full, c1Valid, c1Sop, c1Full} = '0;
      {c0ReqType, c1ReqType, c0Len, c1Len, c1Vc} = '0;
      c0Addr = '0;
      c1Addr = '0;
      {paddr, psel, penable, pwrite, pwdata} = '0;
      expStatus = '0;
      expMask = '1;
      expCount = 0;
      expFirstValid = 1'b0;
      expFirstIdx = '0;
      reset = 1'b1;
      repeat (2) @(negedge clk);
      reset = 1'b0;

      // Legal traffic raises nothing
      alignedAddr(ccipCheckPkg::Len1Cl, base);
      sendRead(ccipCheckPkg::ReqRdLineS, ccipCheckPkg::Len1Cl, base, 1'b0);
      sendRead(ccipCheckPkg::ReqRdLineI, ccipCheckPkg::Len1Cl, base, 1'b0);
      for (int l = 0; l < 4; l += 1 + int'(l == 1)) begin
         alignedAddr(2'(l), base);
         writeBurst(2'(l), base, 2'(l), 0);
      end
      checkRegs();

      // One read rule per beat
      sendRead(ccipCheckPkg::ReqWrLineI, ccipCheckPkg::Len1Cl, base, 1'b0);
      checkRegs();
      clearStatus('1);
      sendRead(ccipCheckPkg::ReqRdLineS, ccipCheckPkg::Len3Cl, base, 1'b0);
      checkRegs();
      clearStatus('1);
      sendRead(ccipCheckPkg::ReqRdLineS, ccipCheckPkg::Len2Cl, base | 42'd1, 1'b0);
      checkRegs();
      clearStatus('1);
      sendRead(ccipCheckPkg::ReqRdLineI, ccipCheckPkg::Len1Cl, base, 1'b1);
      checkRegs();
      clearStatus('1);
      // First-violation register reloads only after a write
      apbWrite(ccipCheckPkg::RegFirst, 32'd0);
      expFirstValid = 1'b0;
      sendRead(ccipCheckPkg::ReqRdLineS, ccipCheckPkg::Len4Cl, base | 42'd2, 1'b1);
      checkRegs();

      // Write rules
      sendWrite(ccipCheckPkg::ReqWrLineI, ccipCheckPkg::Len1Cl, base, 2'd0, 1'b0, 1'b0);
      noteViol(violBit(ccipCheckPkg::WrSopError));
      checkRegs();
      clearStatus('1);
      alignedAddr(ccipCheckPkg::Len4Cl, base);
      // Two beats of a 4-line burst, then a SOP beat in its middle
      sendWrite(ccipCheckPkg::ReqWrLineM, ccipCheckPkg::Len4Cl, base, 2'd1, 1'b1, 1'b0);
      sendWrite(ccipCheckPkg::ReqWrLineM, ccipCheckPkg::Len4Cl, base + 42'd1, 2'd1, 1'b0, 1'b0);
      sendWrite(ccipCheckPkg::ReqWrLineM, ccipCheckPkg::Len4Cl, base, 2'd1, 1'b1, 1'b0);
      noteViol(violBit(ccipCheckPkg::WrSopError));
      // SOP beat opened a new burst, finish it and follow with a clean one
      writeBurst(ccipCheckPkg::Len4Cl, base, 2'd1, 1);
      writeBurst(ccipCheckPkg::Len2Cl, base, 2'd2, 0);
      checkRegs();
      // Wrong address, then wrong vc, then wrong length on a later beat
      for (int k = 0; k < 3; k++) begin
         sendWrite(ccipCheckPkg::ReqWrLineM, ccipCheckPkg::Len2Cl, base, 2'd0, 1'b1, 1'b0);
         sendWrite(ccipCheckPkg::ReqWrLineM, k == 2 ? ccipCheckPkg::Len4Cl : ccipCheckPkg::Len2Cl,
                   base + 42'(k == 0 ? 5 : 1), k == 1 ? 2'd3 : 2'd0, 1'b0, 1'b0);
         noteViol(violBit(ccipCheckPkg::WrBurstMismatch));
         checkRegs();
         clearStatus('1);
      end
      sendWrite(ccipCheckPkg::ReqWrLineI, ccipCheckPkg::Len3Cl, base, 2'd0, 1'b1, 1'b0);
      noteViol(violBit(ccipCheckPkg::WrIllegalLen));
      sendWrite(ccipCheckPkg::ReqWrLineI, ccipCheckPkg::Len4Cl, base | 42'd2, 2'd0, 1'b1, 1'b0);
      noteViol(violBit(ccipCheckPkg::WrMisaligned));
      sendWrite(ccipCheckPkg::ReqRdLineS, ccipCheckPkg::Len1Cl, base, 2'd0, 1'b1, 1'b0);
      noteViol(violBit(ccipCheckPkg::WrBadType));
      sendWrite(ccipCheckPkg::ReqWrLineI, ccipCheckPkg::Len1Cl, base, 2'd0, 1'b1, 1'b1);
      noteViol(violBit(ccipCheckPkg::WrOverflow));
      checkRegs();

      // Partial clear, then irq against the mask
      clearStatus(violBit(ccipCheckPkg::WrMisaligned) | violBit(ccipCheckPkg::WrOverflow));
      checkRegs();
      clearStatus('1);
      sendRead(ccipCheckPkg::ReqRdLineS, ccipCheckPkg::Len1Cl, base, 1'b1);
      expMask = ~violBit(ccipCheckPkg::RdOverflow);
      apbWrite(ccipCheckPkg::RegMask, {22'd0, expMask});
      checkRegs();
      expMask = '1;
      apbWrite(ccipCheckPkg::RegMask, {22'd0, expMask});
      apbRead(ccipCheckPkg::RegMask, rdData, rdErr);
      checkValue("RegMask", {22'd0, expMask}, rdData);
      checkRegs();
      apbRead(4'h2, rdData, rdErr);
      checkValue("pslverr", 32'd1, {31'd0, rdErr});
      apbRead(4'h6, rdData, rdErr);
      checkValue("pslverr", 32'd1, {31'd0, rdErr});

      // Saturation, then clear by write
      apbWrite(ccipCheckPkg::RegCount, 32'd0);
      expCount = 0;
      @(negedge clk);
      c0Valid = 1'b1;
      c0Full = 1'b1;
      c0ReqType = ccipCheckPkg::ReqRdLineS;
      c0Len = ccipCheckPkg::Len1Cl;
      repeat (260) begin
         @(negedge clk);
         noteViol(violBit(ccipCheckPkg::RdOverflow));
      end
      c0Valid = 1'b0;
      c0Full = 1'b0;
      checkRegs();
      apbWrite(ccipCheckPkg::RegCount, 32'd0);
      expCount = 0;
      checkRegs();

      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: flist.f
hw/ccipCheckPkg.sv
hw/readRequestChecker.sv
hw/writeBurstTracker.sv
hw/violationCounter.sv
hw/statusRegs.sv
hw/ccipChecker.sv
bench/ccipCheckerTb.sv

// File: hw/ccipCheckPkg.sv
/*
 * Shared widths, encodings and register map of the request port checker
 * Lengths use the 2-bit line count encoding, so 0 means one cache line
 * Register offsets are byte addresses on a 4-bit APB address bus
 */
package ccipCheckPkg;

   // Request header field widths
   localparam int AddrWidth = 42;
   localparam int VcWidth = 2;
   localparam int LenWidth = 2;
   localparam int ReqTypeWidth = 4;

   // Cache-line length encodings
   localparam logic [LenWidth-1:0] Len1Cl = 2'd0;
   localparam logic [LenWidth-1:0] Len2Cl = 2'd1;
   localparam logic [LenWidth-1:0] Len3Cl = 2'd2;
   localparam logic [LenWidth-1:0] Len4Cl = 2'd3;

   // Request types seen on the two channels
   localparam logic [ReqTypeWidth-1:0] ReqWrLineI = 4'h0;
   localparam logic [ReqTypeWidth-1:0] ReqWrLineM = 4'h1;
   localparam logic [ReqTypeWidth-1:0] ReqRdLineS = 4'h4;
   localparam logic [ReqTypeWidth-1:0] ReqRdLineI = 4'h6;

   // Violation vector layout, read slice in the low bits
   localparam int NumViolations = 10;
   localparam int ViolIdxWidth = 4;
   localparam int RdViolWidth = 4;
   localparam int WrViolWidth = 6;
   localparam int WrSliceLsb = RdViolWidth;

   localparam int RdIllegalLen = 0;
   localparam int RdMisaligned = 1;
   localparam int RdBadType = 2;
   localparam int RdOverflow = 3;
   localparam int WrIllegalLen = 4;
   localparam int WrMisaligned = 5;
   localparam int WrSopError = 6;
   localparam int WrBurstMismatch = 7;
   localparam int WrOverflow = 8;
   localparam int WrBadType = 9;

   // Saturating event count
   localparam int CountWidth = 8;

   // APB bus and register map
   localparam int ApbAddrWidth = 4;
   localparam int ApbDataWidth = 32;
   localparam logic [ApbAddrWidth-1:0] RegStatus = 4'h0;
   localparam logic [ApbAddrWidth-1:0] RegMask = 4'h4;
   localparam logic [ApbAddrWidth-1:0] RegCount = 4'h8;
   localparam logic [ApbAddrWidth-1:0] RegFirst = 4'hC;

   // Alignment rule for multi-line requests, same on both channels
   // 2 lines need bit 0 clear, 4 lines need bits 1:0 clear
   function automatic logic isMisaligned(input logic [LenWidth-1:0] len,
                                         input logic [1:0] addrLow);
      return ((len == Len2Cl) && addrLow[0]) ||
             ((len == Len4Cl) && (addrLow != 2'b00));
   endfunction

endpackage

// File: hw/ccipChecker.sv
/*
 * Top of the request port protocol checker
 * Watches channel 0 reads and channel 1 writes, never stalls traffic
 * Status readable two cycles after the offending beat
 */
`timescale 1ns/1ps

module ccipChecker (
   input  logic                                    clk,
   input  logic                                    reset,
   // Channel 0, read requests
   input  logic                                    c0Valid,
   input  logic [ccipCheckPkg::ReqTypeWidth-1:0]   c0ReqType,
   input  logic [ccipCheckPkg::LenWidth-1:0]       c0Len,
   input  logic [ccipCheckPkg::AddrWidth-1:0]      c0Addr,
   input  logic                                    c0Full,
   // Channel 1, write requests
   input  logic                                    c1Valid,
   input  logic [ccipCheckPkg::ReqTypeWidth-1:0]   c1ReqType,
   input  logic [ccipCheckPkg::LenWidth-1:0]       c1Len,
   input  logic [ccipCheckPkg::AddrWidth-1:0]      c1Addr,
   input  logic [ccipCheckPkg::VcWidth-1:0]        c1Vc,
   input  logic                                    c1Sop,
   input  logic                                    c1Full,
   // APB slave
   input  logic [ccipCheckPkg::ApbAddrWidth-1:0]   paddr,
   input  logic                                    psel,
   input  logic                                    penable,
   input  logic                                    pwrite,
   input  logic [ccipCheckPkg::ApbDataWidth-1:0]   pwdata,
   output logic [ccipCheckPkg::ApbDataWidth-1:0]   prdata,
   output logic                                    pready,
   output logic                                    pslverr,
   output logic                                    irq
);

   logic [ccipCheckPkg::RdViolWidth-1:0] rdViol;
   logic [ccipCheckPkg::WrViolWidth-1:0] wrViol;
   logic [ccipCheckPkg::NumViolations-1:0] viol;
   logic [ccipCheckPkg::CountWidth-1:0] count;
   logic countClear;

   // Write slice above the read slice
   assign viol = {wrViol, rdViol};

   readRequestChecker readCheck (
      .clk(clk), .reset(reset),
      .c0Valid(c0Valid), .c0ReqType(c0ReqType), .c0Len(c0Len),
      .c0Addr(c0Addr), .c0Full(c0Full),
      .rdViol(rdViol)
   );

   writeBurstTracker writeTrack (
      .clk(clk), .reset(reset),
      .c1Valid(c1Valid), .c1ReqType(c1ReqType), .c1Len(c1Len),
      .c1Addr(c1Addr), .c1Vc(c1Vc), .c1Sop(c1Sop), .c1Full(c1Full),
      .wrViol(wrViol)
   );

   violationCounter violCount (
      .clk(clk), .reset(reset),
      .viol(viol), .countClear(countClear), .count(count)
   );

   statusRegs regs (
      .clk(clk), .reset(reset),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .viol(viol), .count(count), .countClear(countClear), .irq(irq)
   );

endmodule

// File: hw/readRequestChecker.sv
/*
 * Channel 0 read request checks: type, length, alignment, overflow
 * Every valid cycle is one request, there is no handshake
 * Each violation pulses for one cycle, the cycle after the beat
 */
`timescale 1ns/1ps

module readRequestChecker (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    c0Valid,
   input  logic [ccipCheckPkg::ReqTypeWidth-1:0]   c0ReqType,
   input  logic [ccipCheckPkg::LenWidth-1:0]       c0Len,
   input  logic [ccipCheckPkg::AddrWidth-1:0]      c0Addr,
   input  logic                                    c0Full,
   output logic [ccipCheckPkg::RdViolWidth-1:0]    rdViol
);

   logic isRead;
   logic [ccipCheckPkg::RdViolWidth-1:0] rdNext;

   always_comb begin
      // Only the two read line types are legal here
      isRead = (c0ReqType == ccipCheckPkg::ReqRdLineS) ||
               (c0ReqType == ccipCheckPkg::ReqRdLineI);

      rdNext = '0;

      // Wrong request type on the read channel
      rdNext[ccipCheckPkg::RdBadType] = c0Valid && !isRead;

      // 3-line requests do not exist
      rdNext[ccipCheckPkg::RdIllegalLen] = c0Valid && (c0Len == ccipCheckPkg::Len3Cl);

      // Multi-line base must sit on its natural boundary
      rdNext[ccipCheckPkg::RdMisaligned] =
         c0Valid && ccipCheckPkg::isMisaligned(c0Len, c0Addr[1:0]);

      // Push while the port reports full
      rdNext[ccipCheckPkg::RdOverflow] = c0Valid && c0Full;
   end

   // One-cycle pulses, registered
   always_ff @(posedge clk) begin
      if (reset) begin
         rdViol <= '0;
      end else begin
         rdViol <= rdNext;
      end
   end

endmodule

// File: hw/statusRegs.sv
/*
 * APB register block, no wait states, pready tied high
 * Status is write-1-to-clear, a new event in the same cycle wins
 * Any write to the count offset clears the count
 * Unmapped offsets answer with pslverr and read as zero
 */
`timescale 1ns/1ps

module statusRegs (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic [ccipCheckPkg::ApbAddrWidth-1:0]    paddr,
   input  logic                                     psel,
   input  logic                                     penable,
   input  logic                                     pwrite,
   input  logic [ccipCheckPkg::ApbDataWidth-1:0]    pwdata,
   output logic [ccipCheckPkg::ApbDataWidth-1:0]    prdata,
   output logic                                     pready,
   output logic                                     pslverr,
   input  logic [ccipCheckPkg::NumViolations-1:0]   viol,
   input  logic [ccipCheckPkg::CountWidth-1:0]      count,
   output logic                                     countClear,
   output logic                                     irq
);

   logic [ccipCheckPkg::NumViolations-1:0] status;
   logic [ccipCheckPkg::NumViolations-1:0] mask;
   logic [ccipCheckPkg::NumViolations-1:0] statusClr;
   logic firstValid;
   logic [ccipCheckPkg::ViolIdxWidth-1:0] firstIdx;
   logic [ccipCheckPkg::ViolIdxWidth-1:0] lowIdx;
   logic addrHit;
   logic wrEn;
   logic firstWrite;

   always_comb begin
      // All four offsets are word aligned
      addrHit = (paddr[1:0] == 2'b00);
      // Writes land in the access cycle
      wrEn = psel && penable && pwrite;
      statusClr = (wrEn && (paddr == ccipCheckPkg::RegStatus)) ?
                  pwdata[ccipCheckPkg::NumViolations-1:0] : '0;
      countClear = wrEn && (paddr == ccipCheckPkg::RegCount);
      firstWrite = wrEn && (paddr == ccipCheckPkg::RegFirst);

      // Lowest set index, scanned from the top down
      lowIdx = '0;
      for (int i = ccipCheckPkg::NumViolations - 1; i >= 0; i--) begin
         if (viol[i]) begin
            lowIdx = ccipCheckPkg::ViolIdxWidth'(i);
         end
      end

      // Read mux
      prdata = '0;
      case (paddr)
         ccipCheckPkg::RegStatus: prdata[ccipCheckPkg::NumViolations-1:0] = status;
         ccipCheckPkg::RegMask: prdata[ccipCheckPkg::NumViolations-1:0] = mask;
         ccipCheckPkg::RegCount: prdata[ccipCheckPkg::CountWidth-1:0] = count;
         ccipCheckPkg::RegFirst: begin
            prdata[ccipCheckPkg::ApbDataWidth-1] = firstValid;
            prdata[ccipCheckPkg::ViolIdxWidth-1:0] = firstIdx;
         end
         default: prdata = '0;
      endcase
   end

   assign pready = 1'b1;

   always_ff @(posedge clk) begin
      if (reset) begin
         status <= '0;
         mask <= '1;
         firstValid <= 1'b0;
         firstIdx <= '0;
         pslverr <= 1'b0;
         irq <= 1'b0;
      end else begin
         // Set has priority over clear
         status <= (status & ~statusClr) | viol;
         if (wrEn && (paddr == ccipCheckPkg::RegMask)) begin
            mask <= pwdata[ccipCheckPkg::NumViolations-1:0];
         end
         // Capture once, hold until software writes the register
         if (firstWrite) begin
            firstValid <= 1'b0;
         end
         if ((!firstValid || firstWrite) && (|viol)) begin
            firstValid <= 1'b1;
            firstIdx <= lowIdx;
         end
         // Decoded in setup so it is up during the access cycle
         pslverr <= psel && !penable && !addrHit;
         irq <= |(status & mask);
      end
   end

endmodule

// File: hw/violationCounter.sv
/*
 * Counts violation events, every set bit of the vector is one event
 * Saturates at the top of the count range
 * Clear beats the increment in the same cycle
 */
`timescale 1ns/1ps

module violationCounter (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic [ccipCheckPkg::NumViolations-1:0]   viol,
   input  logic                                     countClear,
   output logic [ccipCheckPkg::CountWidth-1:0]      count
);

   logic [ccipCheckPkg::ViolIdxWidth-1:0] setBits;
   // One extra bit to catch the carry out
   logic [ccipCheckPkg::CountWidth:0] sum;

   always_comb begin
      // Population count of this cycle's pulses
      setBits = '0;
      for (int i = 0; i < ccipCheckPkg::NumViolations; i++) begin
         setBits = setBits + ccipCheckPkg::ViolIdxWidth'(viol[i]);
      end
      sum = {1'b0, count} + (ccipCheckPkg::CountWidth + 1)'(setBits);
   end

   always_ff @(posedge clk) begin
      if (reset || countClear) begin
         count <= '0;
      end else if (sum[ccipCheckPkg::CountWidth]) begin
         // Stick at the max
         count <= '1;
      end else begin
         count <= sum[ccipCheckPkg::CountWidth-1:0];
      end
   end

endmodule

// File: hw/writeBurstTracker.sv
/*
 * Channel 1 write checks with burst tracking
 * Beats of a burst may have idle cycles between them
 * A SOP beat inside a burst is flagged and then opens a fresh burst
 * Bad type or bad length/alignment on the SOP beat keeps the FSM in Idle
 */
`timescale 1ns/1ps

module writeBurstTracker (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    c1Valid,
   input  logic [ccipCheckPkg::ReqTypeWidth-1:0]   c1ReqType,
   input  logic [ccipCheckPkg::LenWidth-1:0]       c1Len,
   input  logic [ccipCheckPkg::AddrWidth-1:0]      c1Addr,
   input  logic [ccipCheckPkg::VcWidth-1:0]        c1Vc,
   input  logic                                    c1Sop,
   input  logic                                    c1Full,
   output logic [ccipCheckPkg::WrViolWidth-1:0]    wrViol
);

   // FSM state, high while a multi-line burst is open
   logic inBurst;
   // Index of the next expected beat within the burst
   logic [ccipCheckPkg::LenWidth-1:0] beatIdx;

   // Header of the opening beat
   logic [ccipCheckPkg::AddrWidth-1:0]    baseAddr;
   logic [ccipCheckPkg::VcWidth-1:0]      heldVc;
   logic [ccipCheckPkg::LenWidth-1:0]     heldLen;
   logic [ccipCheckPkg::ReqTypeWidth-1:0] heldType;

   logic isWrite;
   logic startBeat;
   logic sopErr;
   logic illegalLen;
   logic misaligned;
   logic mismatch;
   logic lastBeat;
   logic openBurst;
   logic [ccipCheckPkg::WrViolWidth-1:0] wrNext;

   always_comb begin
      isWrite = (c1ReqType == ccipCheckPkg::ReqWrLineI) ||
                (c1ReqType == ccipCheckPkg::ReqWrLineM);

      // Any beat in Idle, or a SOP beat in a burst, is judged as a start
      startBeat = c1Valid && (!inBurst || c1Sop);

      // Idle wants SOP high, a burst wants SOP low
      sopErr = c1Valid && (inBurst == c1Sop);

      // Length and alignment only checked on a SOP beat
      illegalLen = startBeat && c1Sop && (c1Len == ccipCheckPkg::Len3Cl);
      misaligned = startBeat && c1Sop && ccipCheckPkg::isMisaligned(c1Len, c1Addr[1:0]);

      // Later beats must repeat the opening header, address stepping by one
      mismatch = c1Valid && inBurst && !c1Sop &&
                 ((c1Addr != baseAddr + ccipCheckPkg::AddrWidth'(beatIdx)) ||
                  (c1Vc != heldVc) ||
                  (c1Len != heldLen) ||
                  (c1ReqType != heldType));

      lastBeat = (beatIdx == heldLen);

      // Clean multi-line SOP beat opens a burst
      openBurst = startBeat && c1Sop && isWrite && !illegalLen && !misaligned &&
                  ((c1Len == ccipCheckPkg::Len2Cl) || (c1Len == ccipCheckPkg::Len4Cl));

      wrNext = '0;
      wrNext[ccipCheckPkg::WrIllegalLen - ccipCheckPkg::WrSliceLsb] = illegalLen;
      wrNext[ccipCheckPkg::WrMisaligned - ccipCheckPkg::WrSliceLsb] = misaligned;
      wrNext[ccipCheckPkg::WrSopError - ccipCheckPkg::WrSliceLsb] = sopErr;
      wrNext[ccipCheckPkg::WrBurstMismatch - ccipCheckPkg::WrSliceLsb] = mismatch;
      wrNext[ccipCheckPkg::WrOverflow - ccipCheckPkg::WrSliceLsb] = c1Valid && c1Full;
      wrNext[ccipCheckPkg::WrBadType - ccipCheckPkg::WrSliceLsb] = c1Valid && !isWrite;
   end

   // FSM, beat counter and violation pulses
   always_ff @(posedge clk) begin
      if (reset) begin
         inBurst <= 1'b0;
         beatIdx <= '0;
         wrViol <= '0;
      end else begin
         wrViol <= wrNext;
         if (startBeat) begin
            // Second beat of a new burst is index 1
            inBurst <= openBurst;
            beatIdx <= 2'd1;
         end else if (c1Valid && inBurst) begin
            if (lastBeat) begin
               inBurst <= 1'b0;
            end
            beatIdx <= beatIdx + 2'd1;
         end
      end
   end

   // Opening header capture
   always_ff @(posedge clk) begin
      if (openBurst) begin
         baseAddr <= c1Addr;
         heldVc <= c1Vc;
         heldLen <= c1Len;
         heldType <= c1ReqType;
      end
   end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module ccipCheckerTb -f flist.f

output=$(./obj_dir/VccipCheckerTb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
   exit 0
else
   exit 1
fi
